/* sd_write_macros.svh */
// shared sizing defines for the SD write path, included by the RTL and the testbench
`ifndef SD_WRITE_MACROS_SVH
`define SD_WRITE_MACROS_SVH

// block size port width in bytes, 10 bits covers a 512-byte block
`define SD_MAX_BLOCK_BITS 10

// word buffer depth, one full 512-byte block of 32-bit words
`define SD_FIFO_DEPTH 128

// card clock divisor width
`define SD_CLK_DIV_BITS 8

`endif

/* sd_write_pkg.sv */
// types shared by the SD write path and its testbench, imported with a wildcard
package sd_write_pkg;

  // block writer sequence, one state per bus phase
  typedef enum logic [3:0] {
    READY,
    START_BIT,
    DAT,
    CRC,
    END_BIT,
    BUS_SWITCH,        // bus turnaround before the status token
    STATUS_START_BIT,
    STATUS,
    STATUS_END_BIT,
    BUSY,
    DONE
  } dat_tx_state_e;

  // host writes whole words, the writer takes them apart byte by byte
  typedef union packed {
    logic [31:0]      word;
    logic [3:0][7:0]  bytes;   // bytes[0] is word[7:0], sent first
  } sd_word_u;

endpackage

/* sd_clk_gen.sv */
// SD card clock divider, also drives the rising and falling enable strobes for the writer
`timescale 1ns/1ps

`include "sd_write_macros.svh"

module sd_clk_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [`SD_CLK_DIV_BITS-1:0] clk_div_i,
  output logic                        sd_clk_o,
  output logic                        sd_clk_en_p_o,
  output logic                        sd_clk_en_n_o,
  output logic                        div_1_o
);

  logic [`SD_CLK_DIV_BITS-1:0] div_cnt_q;
  logic [`SD_CLK_DIV_BITS-1:0] div_last;
  logic                        cnt_at_last;
  logic                        sd_clk_q;

  assign div_1_o  = (clk_div_i == '0);
  assign div_last = clk_div_i - 1'b1;

  // >= so a divisor lowered mid-count still wraps
  assign cnt_at_last = (div_cnt_q >= div_last);

  // card clock toggles every N system cycles, so the period is 2N
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
      sd_clk_q  <= 1'b0;
    end else if (div_1_o) begin
      div_cnt_q <= '0;
    end else if (cnt_at_last) begin
      div_cnt_q <= '0;
      sd_clk_q  <= ~sd_clk_q;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // strobes sit in the cycle just before the matching card clock edge
  assign sd_clk_en_p_o = div_1_o | (cnt_at_last & ~sd_clk_q);
  assign sd_clk_en_n_o = div_1_o | (cnt_at_last & sd_clk_q);

  // divide-by-one passes the system clock straight through
  assign sd_clk_o = div_1_o ? clk_i : sd_clk_q;

endmodule

/* crc16_write.sv */
// serial CRC16 for one DAT lane, absorbs data bits then shifts the remainder out MSB first
`timescale 1ns/1ps

module crc16_write (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sd_clk_en_i,
  input  logic shift_out_crc16_i,
  input  logic dat_ser_i,
  output logic crc_ser_o
);

  // CRC-CCITT, x^16 + x^12 + x^5 + 1
  localparam logic [15:0] Poly = 16'h1021;

  logic [15:0] crc_q;
  logic [15:0] crc_d;
  logic        feedback;

  assign feedback = dat_ser_i ^ crc_q[15];

  always_comb begin
    crc_d = {crc_q[14:0], 1'b0};  // shift-out fills with zeros
    if (!shift_out_crc16_i && feedback) begin
      crc_d = crc_d ^ Poly;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      crc_q <= '0;
    end else if (sd_clk_en_i) begin
      crc_q <= crc_d;
    end
  end

  // valid as the next CRC bit only while shifting out
  assign crc_ser_o = crc_q[15];

endmodule

/* write_word_fifo.sv */
// first-word-fall-through word buffer between the host and the block writer
`timescale 1ns/1ps

`include "sd_write_macros.svh"

module write_word_fifo
  import sd_write_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wr_en_i,
  input  sd_word_u wr_data_i,
  input  logic     rd_en_i,
  output sd_word_u rd_data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int Depth = `SD_FIFO_DEPTH;
  localparam int AddrW = $clog2(Depth);
  localparam int CntW  = AddrW + 1;

  localparam logic [AddrW-1:0] LastAddr = AddrW'(Depth - 1);

  sd_word_u         mem [Depth];
  logic [AddrW-1:0] wr_ptr_q;
  logic [AddrW-1:0] rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             push;
  logic             pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  assign push = wr_en_i & ~full_o;   // dropped when full
  assign pop  = rd_en_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastAddr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastAddr) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // head word is always on the output
  assign rd_data_o = mem[rd_ptr_q];

endmodule

/* dat_write.sv */
// block write sequencer on DAT, sends data and lane CRCs then checks the status token and busy
`timescale 1ns/1ps

`include "sd_write_macros.svh"

module dat_write
  import sd_write_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          sd_clk_en_p_i,
  input  logic                          sd_clk_en_n_i,
  input  logic                          div_1_i,
  input  logic                          rst_ni,
  input  logic                          dat0_i,
  input  logic                          start_i,
  input  logic [`SD_MAX_BLOCK_BITS-1:0] block_size_i,  // bytes
  input  logic                          bus_width_is_4_i,
  input  sd_word_u                      data_i,
  output logic [3:0]                    dat_o,
  output logic                          dat_en_o,
  output logic                          next_word_o,
  output logic                          done_o,
  output logic                          crc_err_o,
  output logic                          end_bit_err_o
);

  // room for block_size * 8 + 16 clocks
  localparam int CntW = `SD_MAX_BLOCK_BITS + 4;

  dat_tx_state_e   state_q, state_d;
  logic [CntW-1:0] counter_q, counter_d;
  logic [CntW-1:0] cnt_inc;
  logic [CntW-1:0] req_clks;
  logic [CntW-1:0] crc_last;
  logic            start_pend_q;
  sd_word_u        buf_q, buf_d;
  logic            end_bit_err_q, end_bit_err_d;
  logic [2:0]      status_q, status_d;
  logic [3:0]      dat;
  logic [3:0]      dat_div1_q;
  logic [3:0]      dat_divn_q;
  logic [3:0]      crc_lane;
  logic            shift_out_crc;

  assign cnt_inc  = counter_q + 1'b1;
  assign req_clks = bus_width_is_4_i ? {3'b000, block_size_i, 1'b0}  // 2 clocks per byte
                                     : {1'b0, block_size_i, 3'b000}; // 8 clocks per byte
  assign crc_last = req_clks + CntW'(16);

  // hold a start strobe that lands between card clock enables
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      start_pend_q <= 1'b0;
    end else if (state_q != READY) begin
      start_pend_q <= 1'b0;
    end else if (start_i) begin
      start_pend_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      READY:            if (start_i || start_pend_q) state_d = START_BIT;
      START_BIT:        state_d = DAT;
      DAT:              if (cnt_inc == req_clks) state_d = CRC;
      CRC:              if (cnt_inc == crc_last) state_d = END_BIT;
      END_BIT:          state_d = BUS_SWITCH;
      BUS_SWITCH:       if (cnt_inc == CntW'(2)) state_d = STATUS_START_BIT;
      STATUS_START_BIT: state_d = STATUS;
      STATUS:           if (cnt_inc == CntW'(3)) state_d = STATUS_END_BIT;
      STATUS_END_BIT:   state_d = BUSY;
      BUSY:             if (dat0_i) state_d = DONE;  // card releases DAT0
      DONE:             state_d = READY;
      default:          state_d = READY;
    endcase
  end

  always_comb begin
    dat_en_o      = 1'b0;
    dat           = 4'hf;
    next_word_o   = 1'b0;
    done_o        = 1'b0;
    crc_err_o     = 1'b0;
    end_bit_err_o = 1'b0;
    shift_out_crc = 1'b1;
    counter_d     = '0;
    buf_d         = buf_q;
    end_bit_err_d = end_bit_err_q;
    status_d      = status_q;

    case (state_q)
      START_BIT: begin
        dat_en_o      = 1'b1;
        dat           = bus_width_is_4_i ? 4'h0 : 4'he;
        buf_d         = data_i;   // first word
        end_bit_err_d = 1'b0;
        status_d      = '0;
      end
      DAT: begin
        dat_en_o      = 1'b1;
        shift_out_crc = 1'b0;
        counter_d     = cnt_inc;
        if (bus_width_is_4_i) begin
          next_word_o = sd_clk_en_p_i & (counter_q[2:0] == 3'd0);
          if (counter_q[2:0] == 3'd7) begin
            buf_d = data_i;
          end else if (counter_q[0]) begin
            buf_d.bytes = {8'h00, buf_q.bytes[3:1]};
          end
          // high nibble first
          dat = counter_q[0] ? buf_q.bytes[0][3:0] : buf_q.bytes[0][7:4];
        end else begin
          next_word_o = sd_clk_en_p_i & (counter_q[4:0] == 5'd0);
          if (counter_q[4:0] == 5'd31) begin
            buf_d = data_i;
          end else if (counter_q[2:0] == 3'd7) begin
            buf_d.bytes = {8'h00, buf_q.bytes[3:1]};
          end else begin
            buf_d.bytes[0] = {buf_q.bytes[0][6:0], 1'b0};
          end
          dat = {3'b111, buf_q.bytes[0][7]};
        end
      end
      CRC: begin
        dat_en_o  = 1'b1;
        counter_d = cnt_inc;
        dat       = bus_width_is_4_i ? crc_lane : {3'b111, crc_lane[0]};
      end
      END_BIT: begin
        dat_en_o = 1'b1;
      end
      BUS_SWITCH: counter_d = cnt_inc;
      STATUS_START_BIT: begin
        if (dat0_i) end_bit_err_d = 1'b1;
      end
      STATUS: begin
        counter_d = cnt_inc;
        status_d  = {status_q[1:0], dat0_i};
      end
      STATUS_END_BIT: begin
        if (!dat0_i) end_bit_err_d = 1'b1;
      end
      DONE: begin
        done_o        = sd_clk_en_p_i;
        crc_err_o     = (status_q != 3'b010);  // 010 means accepted
        end_bit_err_o = end_bit_err_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= READY;
      counter_q     <= '0;
      end_bit_err_q <= 1'b0;
      status_q      <= '0;
    end else if (sd_clk_en_p_i) begin
      state_q       <= state_d;
      counter_q     <= counter_d;
      end_bit_err_q <= end_bit_err_d;
      status_q      <= status_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sd_clk_en_p_i) begin
      buf_q <= buf_d;
    end
  end

  // bus changes half a card clock after the state
  always_ff @(negedge clk_i) begin
    if (!rst_ni) begin
      dat_div1_q <= 4'hf;
    end else begin
      dat_div1_q <= dat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      dat_divn_q <= 4'hf;
    end else if (sd_clk_en_n_i) begin
      dat_divn_q <= dat;
    end
  end

  assign dat_o = div_1_i ? dat_div1_q : dat_divn_q;

  for (genvar i = 0; i < 4; i++) begin : g_crc_lane
    crc16_write crc16_write_inst (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .sd_clk_en_i       (sd_clk_en_p_i),
      .shift_out_crc16_i (shift_out_crc),
      .dat_ser_i         (dat[i]),
      .crc_ser_o         (crc_lane[i])
    );
  end

endmodule

/* sd_write_top.sv */
// SD write path top, wires the clock divider, word buffer and block writer together
`timescale 1ns/1ps

`include "sd_write_macros.svh"

module sd_write_top
  import sd_write_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [`SD_CLK_DIV_BITS-1:0]   clk_div_i,
  input  logic                          wr_en_i,
  input  sd_word_u                      wr_data_i,
  input  logic                          start_i,
  input  logic [`SD_MAX_BLOCK_BITS-1:0] block_size_i,
  input  logic                          bus_width_is_4_i,
  input  logic                          dat0_i,
  output logic                          fifo_full_o,
  output logic                          sd_clk_o,
  output logic [3:0]                    dat_o,
  output logic                          dat_en_o,
  output logic                          done_o,
  output logic                          crc_err_o,
  output logic                          end_bit_err_o
);

  logic     sd_clk_en_p;
  logic     sd_clk_en_n;
  logic     div_1;
  logic     next_word;
  sd_word_u head_word;

  sd_clk_gen sd_clk_gen_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clk_div_i     (clk_div_i),
    .sd_clk_o      (sd_clk_o),
    .sd_clk_en_p_o (sd_clk_en_p),
    .sd_clk_en_n_o (sd_clk_en_n),
    .div_1_o       (div_1)
  );

  write_word_fifo write_word_fifo_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (wr_en_i),
    .wr_data_i (wr_data_i),
    .rd_en_i   (next_word),
    .rd_data_o (head_word),
    .full_o    (fifo_full_o),
    .empty_o   ()              // host loads the whole block before start
  );

  dat_write dat_write_inst (
    .clk_i            (clk_i),
    .sd_clk_en_p_i    (sd_clk_en_p),
    .sd_clk_en_n_i    (sd_clk_en_n),
    .div_1_i          (div_1),
    .rst_ni           (rst_ni),
    .dat0_i           (dat0_i),
    .start_i          (start_i),
    .block_size_i     (block_size_i),
    .bus_width_is_4_i (bus_width_is_4_i),
    .data_i           (head_word),
    .dat_o            (dat_o),
    .dat_en_o         (dat_en_o),
    .next_word_o      (next_word),
    .done_o           (done_o),
    .crc_err_o        (crc_err_o),
    .end_bit_err_o    (end_bit_err_o)
  );

endmodule

/* tb_sd_write.sv */
// testbench for the SD write path, sends blocks into a card model on DAT and checks data, CRC and flags
`timescale 1ns/1ps

`include "sd_write_macros.svh"

module tb_sd_write
  import sd_write_pkg::*;
();

  localparam int ClkPeriodNs   = 20;
  localparam int DivN          = 2;
  localparam int BlockOverhead = 48;    // SD clocks per block besides data and busy
  // two 128-clock blocks, six 16-clock blocks, 40 busy clocks plus the short busy waits
  localparam int WorstSdClks   = 128 + 128 + 6 * 16 + 8 * BlockOverhead + 40 + 16;
  localparam int TimeoutNs     = WorstSdClks * 2 * DivN * ClkPeriodNs + 20000;
  localparam int DoneLimit     = 4000;  // system clocks from start strobe to done
  localparam int StartLimit    = 64;    // SD clocks until the start bit shows up

  logic                          clk;
  logic                          rst_n;
  logic [`SD_CLK_DIV_BITS-1:0]   clk_div;
  logic                          wr_en;
  sd_word_u                      wr_data;
  logic                          start;
  logic [`SD_MAX_BLOCK_BITS-1:0] block_size;
  logic                          bus_width_is_4;
  logic                          dat0;
  logic                          fifo_full;
  logic                          sd_clk;
  logic [3:0]                    dat;
  logic                          dat_en;
  logic                          done;
  logic                          crc_err;
  logic                          end_bit_err;

  integer     seed = 32'hf3915423;
  logic [7:0] exp_bytes[$];    // expected bus order of the current block
  int         done_count = 0;
  logic       tx_active;       // start bit up to end bit
  logic       turnaround;      // end bit up to done
  logic       busy_released;
  logic       got_crc_err;
  logic       got_end_err;

  sd_write_top sd_write_top_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .clk_div_i        (clk_div),
    .wr_en_i          (wr_en),
    .wr_data_i        (wr_data),
    .start_i          (start),
    .block_size_i     (block_size),
    .bus_width_is_4_i (bus_width_is_4),
    .dat0_i           (dat0),
    .fifo_full_o      (fifo_full),
    .sd_clk_o         (sd_clk),
    .dat_o            (dat),
    .dat_en_o         (dat_en),
    .done_o           (done),
    .crc_err_o        (crc_err),
    .end_bit_err_o    (end_bit_err)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriodNs / 2) clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s (at %0t)", what, $time);
    stop_on_failure();
  endtask

  // CRC-CCITT x^16 + x^12 + x^5 + 1, one serial bit, zero start value
  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic din);
    logic [15:0] nxt;
    nxt = {crc[14:0], 1'b0};
    if (din ^ crc[15]) begin
      nxt = nxt ^ 16'h1021;
    end
    return nxt;
  endfunction

  task automatic load_block(input int nbytes);
    logic [31:0] w;
    exp_bytes.delete();
    for (int i = 0; i < nbytes / 4; i++) begin
      w = $random(seed);
      @(posedge clk);
      #2;
      wr_en        = 1'b1;
      wr_data.word = w;
      for (int b = 0; b < 4; b++) begin
        exp_bytes.push_back(w[8*b +: 8]);  // byte 0 leaves first
      end
    end
    @(posedge clk);
    #2;
    wr_en = 1'b0;
    check_value("fifo_full_o", 32'(fifo_full), 32'h0);
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #2;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  // card side, samples DAT on each rising SD clock
  task automatic card_receive(input logic four_bit, input int nbytes);
    logic [15:0] crc_ref[4];
    logic [15:0] crc_rx[4];
    logic [7:0]  rx_byte;
    logic [7:0]  b;
    int          waited;
    waited = 0;
    @(posedge sd_clk);
    while (dat[0] !== 1'b0) begin
      waited++;
      if (waited > StartLimit) begin
        report_failure("no start bit on DAT0 after the start strobe");
      end
      @(posedge sd_clk);
    end
    check_value("dat_o start bit", 32'(dat), four_bit ? 32'h0 : 32'he);
    tx_active = 1'b1;
    for (int l = 0; l < 4; l++) begin
      crc_ref[l] = '0;
      crc_rx[l]  = '0;
    end
    for (int n = 0; n < nbytes; n++) begin
      b = exp_bytes[n];
      if (four_bit) begin
        @(posedge sd_clk);
        rx_byte[7:4] = dat;   // high nibble first
        @(posedge sd_clk);
        rx_byte[3:0] = dat;
        for (int l = 0; l < 4; l++) begin
          crc_ref[l] = crc16_next(crc_ref[l], b[4 + l]);
          crc_ref[l] = crc16_next(crc_ref[l], b[l]);
        end
      end else begin
        for (int k = 7; k >= 0; k--) begin
          @(posedge sd_clk);
          check_value("dat_o[3:1] in 1-bit mode", 32'(dat[3:1]), 32'h7);
          rx_byte[k] = dat[0];
          crc_ref[0] = crc16_next(crc_ref[0], b[k]);
        end
      end
      check_value($sformatf("dat_o byte %0d", n), 32'(rx_byte), 32'(b));
    end
    for (int k = 0; k < 16; k++) begin
      @(posedge sd_clk);
      for (int l = 0; l < 4; l++) begin
        crc_rx[l] = {crc_rx[l][14:0], dat[l]};
      end
    end
    for (int l = 0; l < 4; l++) begin
      if (four_bit || l == 0) begin
        check_value($sformatf("dat_o[%0d] crc16", l), 32'(crc_rx[l]), 32'(crc_ref[l]));
      end else begin
        check_value($sformatf("dat_o[%0d] idle lane", l), 32'(crc_rx[l]), 32'hffff);
      end
    end
    @(posedge sd_clk);
    check_value("dat_o end bit", 32'(dat), 32'hf);
    tx_active  = 1'b0;
    turnaround = 1'b1;
  endtask

  // token bits are driven just after a rising SD clock, the writer samples on the next one
  task automatic card_token(input logic start_bit, input logic [2:0] status,
                            input logic end_bit, input int busy_clks);
    repeat (2) @(posedge sd_clk);   // bus switch
    #2;
    dat0 = start_bit;
    for (int k = 2; k >= 0; k--) begin
      @(posedge sd_clk);
      #2;
      dat0 = status[k];
    end
    @(posedge sd_clk);
    #2;
    dat0 = end_bit;
    @(posedge sd_clk);
    #2;
    if (busy_clks > 0) begin
      dat0 = 1'b0;
      repeat (busy_clks) @(posedge sd_clk);
      #2;
    end
    dat0          = 1'b1;
    busy_released = 1'b1;
  endtask

  task automatic wait_done();
    dat_tx_state_e state;
    int            cycles;
    cycles = 0;
    @(negedge clk);
    while (done !== 1'b1) begin
      cycles++;
      if (cycles > DoneLimit) begin
        state = sd_write_top_inst.dat_write_inst.state_q;
        report_failure($sformatf("done_o never pulsed, writer stuck in %s", state.name()));
      end
      @(negedge clk);
    end
    if (!busy_released) begin
      report_failure("done_o pulsed while the card still held DAT0 low");
    end
    got_crc_err = crc_err;
    got_end_err = end_bit_err;
    turnaround  = 1'b0;
  endtask

  task automatic run_block(input int nbytes, input logic four_bit, input logic start_bit,
                           input logic [2:0] status, input logic end_bit, input int busy_clks,
                           input logic exp_crc_err, input logic exp_end_err);
    int count_before;
    load_block(nbytes);
    block_size     = `SD_MAX_BLOCK_BITS'(nbytes);
    bus_width_is_4 = four_bit;
    busy_released  = 1'b0;
    count_before   = done_count;
    fork
      pulse_start();
      begin
        card_receive(four_bit, nbytes);
        card_token(start_bit, status, end_bit, busy_clks);
      end
      wait_done();
    join
    check_value("crc_err_o", 32'(got_crc_err), 32'(exp_crc_err));
    check_value("end_bit_err_o", 32'(got_end_err), 32'(exp_end_err));
    repeat (4) @(posedge sd_clk);
    check_value("done_o pulse count", 32'(done_count - count_before), 32'h1);
  endtask

  task automatic four_bit_block();
    $display("4-bit 64-byte block, divisor %0d", DivN);
    run_block(64, 1'b1, 1'b0, 3'b010, 1'b1, 4, 1'b0, 1'b0);
  endtask

  task automatic one_bit_block();
    $display("1-bit 16-byte block");
    run_block(16, 1'b0, 1'b0, 3'b010, 1'b1, 2, 1'b0, 1'b0);
  endtask

  task automatic crc_status_error();
    $display("status token 101");
    run_block(8, 1'b1, 1'b0, 3'b101, 1'b1, 1, 1'b1, 1'b0);
  endtask

  task automatic token_framing_errors();
    $display("token with low end bit, then token with high start bit");
    run_block(8, 1'b1, 1'b0, 3'b010, 1'b0, 1, 1'b0, 1'b1);
    run_block(8, 1'b1, 1'b1, 3'b010, 1'b1, 1, 1'b0, 1'b1);
  endtask

  task automatic long_busy_wait();
    $display("busy held for 40 SD clocks");
    run_block(8, 1'b1, 1'b0, 3'b010, 1'b1, 40, 1'b0, 1'b0);
  endtask

  task automatic divide_by_one_blocks();
    $display("divide-by-one, two 8-byte blocks back to back");
    @(posedge clk);
    #2;
    clk_div = '0;
    run_block(8, 1'b1, 1'b0, 3'b010, 1'b1, 2, 1'b0, 1'b0);
    run_block(8, 1'b1, 1'b0, 3'b010, 1'b1, 2, 1'b0, 1'b0);  // needs cleared CRC lanes
  endtask

  // bus ownership, checked mid-cycle where dat_en_o has settled
  always @(negedge clk) begin
    if (tx_active) begin
      check_value("dat_en_o during transfer", 32'(dat_en), 32'h1);
    end
    if (turnaround) begin
      check_value("dat_en_o after end bit", 32'(dat_en), 32'h0);
    end
    if (done === 1'b1) begin
      done_count <= done_count + 1;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("timeout after %0d ns, the tests did not finish", TimeoutNs);
    stop_on_failure();
  end

  initial begin
    clk_div        = `SD_CLK_DIV_BITS'(DivN);
    wr_en          = 1'b0;
    wr_data        = '0;
    start          = 1'b0;
    block_size     = '0;
    bus_width_is_4 = 1'b1;
    dat0           = 1'b1;   // card pulls DAT0 up while idle
    tx_active      = 1'b0;
    turnaround     = 1'b0;
    busy_released  = 1'b0;
    got_crc_err    = 1'b0;
    got_end_err    = 1'b0;
    rst_n          = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    four_bit_block();
    one_bit_block();
    crc_status_error();
    token_framing_errors();
    long_busy_wait();
    divide_by_one_blocks();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* files.f */
+incdir+.
sd_write_pkg.sv
sd_clk_gen.sv
crc16_write.sv
write_word_fifo.sv
dat_write.sv
sd_write_top.sv
tb_sd_write.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SD write testbench with Verilator and runs it, exit status follows the run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sd_write \
  -f files.f -o tb_sd_write_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_sd_write_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation passed"
exit 0
